//--- Makefile
# Verilator flow for the two-input receive path
VERILATOR ?= verilator
FLIST     ?= flist.f
TB_TOP    ?= tb_eth_rx_path
RTL_TOP   ?= eth_rx_path_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= *** PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
rtl/eth_pkg.sv
rtl/eth_mux_2.sv
rtl/eth_type_filter.sv
rtl/eth_rx_path_top.sv
sim/eth_rx_checker.sv
sim/tb_eth_rx_path.sv

//--- rtl/eth_mux_2.sv
// select is sampled only at frame start; enable gates new frames, not one already in progress
`timescale 1ns/1ps

module eth_mux_2
    import eth_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  in0_hdr_valid,
    output logic                  in0_hdr_ready,
    input  logic [ETH_MAC_W-1:0]  in0_dest_mac,
    input  logic [ETH_MAC_W-1:0]  in0_src_mac,
    input  logic [ETH_TYPE_W-1:0] in0_eth_type,
    input  logic [ETH_DATA_W-1:0] in0_tdata,
    input  logic [ETH_KEEP_W-1:0] in0_tkeep,
    input  logic                  in0_tvalid,
    output logic                  in0_tready,
    input  logic                  in0_tlast,
    input  logic                  in0_tuser,

    input  logic                  in1_hdr_valid,
    output logic                  in1_hdr_ready,
    input  logic [ETH_MAC_W-1:0]  in1_dest_mac,
    input  logic [ETH_MAC_W-1:0]  in1_src_mac,
    input  logic [ETH_TYPE_W-1:0] in1_eth_type,
    input  logic [ETH_DATA_W-1:0] in1_tdata,
    input  logic [ETH_KEEP_W-1:0] in1_tkeep,
    input  logic                  in1_tvalid,
    output logic                  in1_tready,
    input  logic                  in1_tlast,
    input  logic                  in1_tuser,

    output logic                  out_hdr_valid,
    input  logic                  out_hdr_ready,
    output logic [ETH_MAC_W-1:0]  out_dest_mac,
    output logic [ETH_MAC_W-1:0]  out_src_mac,
    output logic [ETH_TYPE_W-1:0] out_eth_type,
    output logic [ETH_DATA_W-1:0] out_tdata,
    output logic [ETH_KEEP_W-1:0] out_tkeep,
    output logic                  out_tvalid,
    input  logic                  out_tready,
    output logic                  out_tlast,
    output logic                  out_tuser,

    input  logic                  enable,
    input  logic                  select
);

    mux_state_t state_q, state_d;
    logic       sel_q, sel_d;
    logic       in0_hdr_ready_d, in1_hdr_ready_d;
    logic       in0_tready_d, in1_tready_d;
    logic       out_hdr_valid_d;
    logic       hdr_take;

    // header valid of the input named by the live select
    logic       pick_hdr_valid;

    // channels of the latched input
    logic                  cur_hdr_valid;
    logic                  cur_hdr_ready;
    logic [ETH_MAC_W-1:0]  cur_dest_mac;
    logic [ETH_MAC_W-1:0]  cur_src_mac;
    logic [ETH_TYPE_W-1:0] cur_eth_type;
    logic [ETH_DATA_W-1:0] cur_tdata;
    logic [ETH_KEEP_W-1:0] cur_tkeep;
    logic                  cur_tvalid;
    logic                  cur_tready;
    logic                  cur_tlast;
    logic                  cur_tuser;

    // payload skid stage
    logic                  int_tvalid;
    logic                  tready_int;
    logic                  tready_early;
    logic [ETH_DATA_W-1:0] temp_tdata;
    logic [ETH_KEEP_W-1:0] temp_tkeep;
    logic                  temp_tvalid;
    logic                  temp_tlast;
    logic                  temp_tuser;

    assign pick_hdr_valid = select ? in1_hdr_valid : in0_hdr_valid;

    assign cur_hdr_valid = sel_q ? in1_hdr_valid : in0_hdr_valid;
    assign cur_hdr_ready = sel_q ? in1_hdr_ready : in0_hdr_ready;
    assign cur_dest_mac  = sel_q ? in1_dest_mac  : in0_dest_mac;
    assign cur_src_mac   = sel_q ? in1_src_mac   : in0_src_mac;
    assign cur_eth_type  = sel_q ? in1_eth_type  : in0_eth_type;
    assign cur_tdata     = sel_q ? in1_tdata     : in0_tdata;
    assign cur_tkeep     = sel_q ? in1_tkeep     : in0_tkeep;
    assign cur_tvalid    = sel_q ? in1_tvalid    : in0_tvalid;
    assign cur_tready    = sel_q ? in1_tready    : in0_tready;
    assign cur_tlast     = sel_q ? in1_tlast     : in0_tlast;
    assign cur_tuser     = sel_q ? in1_tuser     : in0_tuser;

    // header is captured on the actual input transfer
    assign hdr_take = cur_hdr_valid & cur_hdr_ready;

    // a beat is only valid once the registered input ready has let it in
    assign int_tvalid = cur_tvalid & cur_tready & (state_q == mux_frame);

    // room next cycle if output drains, both stages empty, or skid stays empty
    assign tready_early = out_tready | (~temp_tvalid & (~out_tvalid | ~int_tvalid));

    always_comb begin
        state_d         = state_q;
        sel_d           = sel_q;
        in0_hdr_ready_d = 1'b0;
        in1_hdr_ready_d = 1'b0;
        out_hdr_valid_d = (out_hdr_valid & ~out_hdr_ready) | hdr_take;

        case (state_q)
            mux_idle: begin
                if (enable && !out_hdr_valid && pick_hdr_valid) begin
                    state_d         = mux_frame;
                    sel_d           = select;
                    in0_hdr_ready_d = ~select;
                    in1_hdr_ready_d = select;
                end
            end
            mux_frame: begin
                // frame ends when the tlast beat is taken in
                if (cur_tvalid && cur_tready && cur_tlast) begin
                    state_d = mux_idle;
                end
            end
            default: state_d = mux_idle;
        endcase

        in0_tready_d = tready_early & (state_d == mux_frame) & ~sel_d;
        in1_tready_d = tready_early & (state_d == mux_frame) & sel_d;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q       <= mux_idle;
            sel_q         <= 1'b0;
            in0_hdr_ready <= 1'b0;
            in1_hdr_ready <= 1'b0;
            in0_tready    <= 1'b0;
            in1_tready    <= 1'b0;
            out_hdr_valid <= 1'b0;
        end else begin
            state_q       <= state_d;
            sel_q         <= sel_d;
            in0_hdr_ready <= in0_hdr_ready_d;
            in1_hdr_ready <= in1_hdr_ready_d;
            in0_tready    <= in0_tready_d;
            in1_tready    <= in1_tready_d;
            out_hdr_valid <= out_hdr_valid_d;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_take) begin
            out_dest_mac <= cur_dest_mac;
            out_src_mac  <= cur_src_mac;
            out_eth_type <= cur_eth_type;
        end
    end

    // valid bits of the output and skid registers
    always_ff @(posedge clk) begin
        if (rst) begin
            tready_int  <= 1'b0;
            out_tvalid  <= 1'b0;
            temp_tvalid <= 1'b0;
        end else begin
            tready_int <= tready_early;
            if (tready_int) begin
                if (out_tready || !out_tvalid) begin
                    out_tvalid <= int_tvalid;
                end else begin
                    temp_tvalid <= int_tvalid;
                end
            end else if (out_tready) begin
                out_tvalid  <= temp_tvalid;
                temp_tvalid <= 1'b0;
            end
        end
    end

    // beat contents follow the same steering as the valid bits
    always_ff @(posedge clk) begin
        if (tready_int) begin
            if (out_tready || !out_tvalid) begin
                out_tdata <= cur_tdata;
                out_tkeep <= cur_tkeep;
                out_tlast <= cur_tlast;
                out_tuser <= cur_tuser;
            end else begin
                temp_tdata <= cur_tdata;
                temp_tkeep <= cur_tkeep;
                temp_tlast <= cur_tlast;
                temp_tuser <= cur_tuser;
            end
        end else if (out_tready) begin
            out_tdata <= temp_tdata;
            out_tkeep <= temp_tkeep;
            out_tlast <= temp_tlast;
            out_tuser <= temp_tuser;
        end
    end

endmodule

//--- rtl/eth_pkg.sv
// shared widths and state encodings; payload is fixed at 64 bits with one keep bit per byte
package eth_pkg;

    // payload beat and byte enable widths
    localparam int ETH_DATA_W = 64;
    localparam int ETH_KEEP_W = ETH_DATA_W / 8;

    // header field widths
    localparam int ETH_MAC_W  = 48;
    localparam int ETH_TYPE_W = 16;

    // frame multiplexer states
    typedef enum logic [0:0] {
        mux_idle  = 1'b0,
        mux_frame = 1'b1
    } mux_state_t;

    // ethertype filter states
    typedef enum logic [1:0] {
        filt_idle = 2'd0,
        filt_hdr  = 2'd1,
        filt_pass = 2'd2,
        filt_drop = 2'd3
    } filt_state_t;

endpackage

//--- rtl/eth_rx_path_top.sv
// two-input receive path with the mux ahead of the ethertype filter; latency depends on back-pressure
`timescale 1ns/1ps

module eth_rx_path_top
    import eth_pkg::*;
#(
    parameter logic [ETH_TYPE_W-1:0] PASS_TYPE_0 = 16'h0800,
    parameter logic [ETH_TYPE_W-1:0] PASS_TYPE_1 = 16'h86DD
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  in0_hdr_valid,
    output logic                  in0_hdr_ready,
    input  logic [ETH_MAC_W-1:0]  in0_dest_mac,
    input  logic [ETH_MAC_W-1:0]  in0_src_mac,
    input  logic [ETH_TYPE_W-1:0] in0_eth_type,
    input  logic [ETH_DATA_W-1:0] in0_tdata,
    input  logic [ETH_KEEP_W-1:0] in0_tkeep,
    input  logic                  in0_tvalid,
    output logic                  in0_tready,
    input  logic                  in0_tlast,
    input  logic                  in0_tuser,

    input  logic                  in1_hdr_valid,
    output logic                  in1_hdr_ready,
    input  logic [ETH_MAC_W-1:0]  in1_dest_mac,
    input  logic [ETH_MAC_W-1:0]  in1_src_mac,
    input  logic [ETH_TYPE_W-1:0] in1_eth_type,
    input  logic [ETH_DATA_W-1:0] in1_tdata,
    input  logic [ETH_KEEP_W-1:0] in1_tkeep,
    input  logic                  in1_tvalid,
    output logic                  in1_tready,
    input  logic                  in1_tlast,
    input  logic                  in1_tuser,

    output logic                  out_hdr_valid,
    input  logic                  out_hdr_ready,
    output logic [ETH_MAC_W-1:0]  out_dest_mac,
    output logic [ETH_MAC_W-1:0]  out_src_mac,
    output logic [ETH_TYPE_W-1:0] out_eth_type,
    output logic [ETH_DATA_W-1:0] out_tdata,
    output logic [ETH_KEEP_W-1:0] out_tkeep,
    output logic                  out_tvalid,
    input  logic                  out_tready,
    output logic                  out_tlast,
    output logic                  out_tuser,

    input  logic                  enable,
    input  logic                  select
);

    // link between the two stages
    logic                  mux_hdr_valid;
    logic                  mux_hdr_ready;
    logic [ETH_MAC_W-1:0]  mux_dest_mac;
    logic [ETH_MAC_W-1:0]  mux_src_mac;
    logic [ETH_TYPE_W-1:0] mux_eth_type;
    logic [ETH_DATA_W-1:0] mux_tdata;
    logic [ETH_KEEP_W-1:0] mux_tkeep;
    logic                  mux_tvalid;
    logic                  mux_tready;
    logic                  mux_tlast;
    logic                  mux_tuser;

    eth_mux_2 mux0 (
        .clk           (clk),
        .rst           (rst),
        .in0_hdr_valid (in0_hdr_valid),
        .in0_hdr_ready (in0_hdr_ready),
        .in0_dest_mac  (in0_dest_mac),
        .in0_src_mac   (in0_src_mac),
        .in0_eth_type  (in0_eth_type),
        .in0_tdata     (in0_tdata),
        .in0_tkeep     (in0_tkeep),
        .in0_tvalid    (in0_tvalid),
        .in0_tready    (in0_tready),
        .in0_tlast     (in0_tlast),
        .in0_tuser     (in0_tuser),
        .in1_hdr_valid (in1_hdr_valid),
        .in1_hdr_ready (in1_hdr_ready),
        .in1_dest_mac  (in1_dest_mac),
        .in1_src_mac   (in1_src_mac),
        .in1_eth_type  (in1_eth_type),
        .in1_tdata     (in1_tdata),
        .in1_tkeep     (in1_tkeep),
        .in1_tvalid    (in1_tvalid),
        .in1_tready    (in1_tready),
        .in1_tlast     (in1_tlast),
        .in1_tuser     (in1_tuser),
        .out_hdr_valid (mux_hdr_valid),
        .out_hdr_ready (mux_hdr_ready),
        .out_dest_mac  (mux_dest_mac),
        .out_src_mac   (mux_src_mac),
        .out_eth_type  (mux_eth_type),
        .out_tdata     (mux_tdata),
        .out_tkeep     (mux_tkeep),
        .out_tvalid    (mux_tvalid),
        .out_tready    (mux_tready),
        .out_tlast     (mux_tlast),
        .out_tuser     (mux_tuser),
        .enable        (enable),
        .select        (select)
    );

    eth_type_filter #(
        .PASS_TYPE_0 (PASS_TYPE_0),
        .PASS_TYPE_1 (PASS_TYPE_1)
    ) filt0 (
        .clk           (clk),
        .rst           (rst),
        .in_hdr_valid  (mux_hdr_valid),
        .in_hdr_ready  (mux_hdr_ready),
        .in_dest_mac   (mux_dest_mac),
        .in_src_mac    (mux_src_mac),
        .in_eth_type   (mux_eth_type),
        .in_tdata      (mux_tdata),
        .in_tkeep      (mux_tkeep),
        .in_tvalid     (mux_tvalid),
        .in_tready     (mux_tready),
        .in_tlast      (mux_tlast),
        .in_tuser      (mux_tuser),
        .out_hdr_valid (out_hdr_valid),
        .out_hdr_ready (out_hdr_ready),
        .out_dest_mac  (out_dest_mac),
        .out_src_mac   (out_src_mac),
        .out_eth_type  (out_eth_type),
        .out_tdata     (out_tdata),
        .out_tkeep     (out_tkeep),
        .out_tvalid    (out_tvalid),
        .out_tready    (out_tready),
        .out_tlast     (out_tlast),
        .out_tuser     (out_tuser)
    );

endmodule

//--- rtl/eth_type_filter.sv
// whole frames pass or drop on the ethertype; a dropped frame's payload is consumed at full rate
`timescale 1ns/1ps

module eth_type_filter
    import eth_pkg::*;
#(
    parameter logic [ETH_TYPE_W-1:0] PASS_TYPE_0 = 16'h0800,
    parameter logic [ETH_TYPE_W-1:0] PASS_TYPE_1 = 16'h86DD
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  in_hdr_valid,
    output logic                  in_hdr_ready,
    input  logic [ETH_MAC_W-1:0]  in_dest_mac,
    input  logic [ETH_MAC_W-1:0]  in_src_mac,
    input  logic [ETH_TYPE_W-1:0] in_eth_type,
    input  logic [ETH_DATA_W-1:0] in_tdata,
    input  logic [ETH_KEEP_W-1:0] in_tkeep,
    input  logic                  in_tvalid,
    output logic                  in_tready,
    input  logic                  in_tlast,
    input  logic                  in_tuser,

    output logic                  out_hdr_valid,
    input  logic                  out_hdr_ready,
    output logic [ETH_MAC_W-1:0]  out_dest_mac,
    output logic [ETH_MAC_W-1:0]  out_src_mac,
    output logic [ETH_TYPE_W-1:0] out_eth_type,
    output logic [ETH_DATA_W-1:0] out_tdata,
    output logic [ETH_KEEP_W-1:0] out_tkeep,
    output logic                  out_tvalid,
    input  logic                  out_tready,
    output logic                  out_tlast,
    output logic                  out_tuser
);

    filt_state_t state_q, state_d;
    logic        hdr_take;
    logic        type_match;

    assign hdr_take   = in_hdr_valid & in_hdr_ready;
    assign type_match = (in_eth_type == PASS_TYPE_0) || (in_eth_type == PASS_TYPE_1);

    // header waits in filt_hdr until downstream takes it
    assign out_hdr_valid = (state_q == filt_hdr);

    // payload goes straight through while passing, and is swallowed while dropping
    assign out_tdata  = in_tdata;
    assign out_tkeep  = in_tkeep;
    assign out_tlast  = in_tlast;
    assign out_tuser  = in_tuser;
    assign out_tvalid = in_tvalid & (state_q == filt_pass);
    assign in_tready  = (state_q == filt_drop) | ((state_q == filt_pass) & out_tready);

    always_comb begin
        state_d = state_q;
        case (state_q)
            filt_idle: begin
                if (hdr_take) begin
                    state_d = type_match ? filt_hdr : filt_drop;
                end
            end
            filt_hdr: begin
                if (out_hdr_ready) begin
                    state_d = filt_pass;
                end
            end
            filt_pass: begin
                if (in_tvalid && out_tready && in_tlast) begin
                    state_d = filt_idle;
                end
            end
            filt_drop: begin
                if (in_tvalid && in_tlast) begin
                    state_d = filt_idle;
                end
            end
            default: state_d = filt_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= filt_idle;
            in_hdr_ready <= 1'b0;
        end else begin
            state_q      <= state_d;
            // ready only while idle, so one header per frame
            in_hdr_ready <= (state_d == filt_idle);
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_take) begin
            out_dest_mac <= in_dest_mac;
            out_src_mac  <= in_src_mac;
            out_eth_type <= in_eth_type;
        end
    end

endmodule

//--- sim/eth_rx_checker.sv
// expected output is built from the DUT input transfers; assumes only the DUT consumes those inputs
`timescale 1ns/1ps

module eth_rx_checker
    import eth_pkg::*;
#(
    parameter logic [ETH_TYPE_W-1:0] PASS_TYPE_0 = 16'h0800,
    parameter logic [ETH_TYPE_W-1:0] PASS_TYPE_1 = 16'h86DD
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       enable,
    input  logic [1:0]                 in_hdr_valid,
    input  logic [1:0]                 in_hdr_ready,
    input  logic [1:0][ETH_MAC_W-1:0]  in_dest_mac,
    input  logic [1:0][ETH_MAC_W-1:0]  in_src_mac,
    input  logic [1:0][ETH_TYPE_W-1:0] in_eth_type,
    input  logic [1:0][ETH_DATA_W-1:0] in_tdata,
    input  logic [1:0][ETH_KEEP_W-1:0] in_tkeep,
    input  logic [1:0]                 in_tvalid,
    input  logic [1:0]                 in_tready,
    input  logic [1:0]                 in_tlast,
    input  logic [1:0]                 in_tuser,
    input  logic                       out_hdr_valid,
    input  logic                       out_hdr_ready,
    input  logic [ETH_MAC_W-1:0]       out_dest_mac,
    input  logic [ETH_MAC_W-1:0]       out_src_mac,
    input  logic [ETH_TYPE_W-1:0]      out_eth_type,
    input  logic [ETH_DATA_W-1:0]      out_tdata,
    input  logic [ETH_KEEP_W-1:0]      out_tkeep,
    input  logic                       out_tvalid,
    input  logic                       out_tready,
    input  logic                       out_tlast,
    input  logic                       out_tuser,
    output int                         error_count,
    output int                         pending_count
);

    // expected headers {dest, src, type} and beats {data, keep, last, user}
    logic [2*ETH_MAC_W+ETH_TYPE_W-1:0] exp_hdr[$];
    logic [ETH_DATA_W+ETH_KEEP_W+1:0]  exp_beat[$];
    logic [1:0]                        frame_pass;
    logic                              enable_q;

    // a frame survives when its ethertype is one of the two pass values
    function automatic bit type_passes(input logic [ETH_TYPE_W-1:0] t);
        return (t == PASS_TYPE_0) || (t == PASS_TYPE_1);
    endfunction

    task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    always @(posedge clk) begin
        logic [2*ETH_MAC_W+ETH_TYPE_W-1:0] h;
        logic [ETH_DATA_W+ETH_KEEP_W+1:0]  b;
        if (rst) begin
            frame_pass = '0;
            enable_q   = 1'b0;
        end else begin
            // header ready may still be up for one cycle after enable falls
            if (!enable && !enable_q && in_hdr_ready != 2'b00) begin
                $display("input header ready rose while enable was low");
                error_count++;
            end
            for (int k = 0; k < 2; k++) begin
                if (in_hdr_valid[k] && in_hdr_ready[k]) begin
                    frame_pass[k] = type_passes(in_eth_type[k]);
                    if (frame_pass[k]) begin
                        exp_hdr.push_back({in_dest_mac[k], in_src_mac[k], in_eth_type[k]});
                    end
                end
                if (in_tvalid[k] && in_tready[k] && frame_pass[k]) begin
                    exp_beat.push_back({in_tdata[k], in_tkeep[k], in_tlast[k], in_tuser[k]});
                end
            end
            if (out_hdr_valid && out_hdr_ready) begin
                if (exp_hdr.size() == 0) begin
                    $display("output header appeared while no frame was expected");
                    error_count++;
                end else begin
                    h = exp_hdr.pop_front();
                    check_field("out_dest_mac", 64'(out_dest_mac),
                                64'(h[ETH_TYPE_W+ETH_MAC_W +: ETH_MAC_W]));
                    check_field("out_src_mac", 64'(out_src_mac), 64'(h[ETH_TYPE_W +: ETH_MAC_W]));
                    check_field("out_eth_type", 64'(out_eth_type), 64'(h[0 +: ETH_TYPE_W]));
                end
            end
            if (out_tvalid && out_tready) begin
                if (exp_beat.size() == 0) begin
                    $display("output beat appeared while no payload was expected");
                    error_count++;
                end else begin
                    b = exp_beat.pop_front();
                    check_field("out_tdata", 64'(out_tdata), 64'(b[ETH_KEEP_W+2 +: ETH_DATA_W]));
                    check_field("out_tkeep", 64'(out_tkeep), 64'(b[2 +: ETH_KEEP_W]));
                    check_field("out_tlast", 64'(out_tlast), 64'(b[1]));
                    check_field("out_tuser", 64'(out_tuser), 64'(b[0]));
                end
            end
            enable_q = enable;
        end
        pending_count = exp_hdr.size() + exp_beat.size();
    end

endmodule

//--- sim/tb_eth_rx_path.sv
// stimulus changes on the falling edge; each wait gives up after WAIT_LIMIT cycles and counts a timeout
`timescale 1ns/1ps

module tb_eth_rx_path
    import eth_pkg::*;
();

    localparam logic [ETH_TYPE_W-1:0] PASS_TYPE_0 = 16'h0800;
    localparam logic [ETH_TYPE_W-1:0] PASS_TYPE_1 = 16'h86DD;
    localparam int                    WAIT_LIMIT  = 200;

    logic                       clk;
    logic                       rst;
    logic                       enable;
    logic                       select;
    logic [1:0]                 hdr_valid;
    logic [1:0][ETH_MAC_W-1:0]  dest_mac;
    logic [1:0][ETH_MAC_W-1:0]  src_mac;
    logic [1:0][ETH_TYPE_W-1:0] eth_type;
    logic [1:0][ETH_DATA_W-1:0] tdata;
    logic [1:0][ETH_KEEP_W-1:0] tkeep;
    logic [1:0]                 tvalid;
    logic [1:0]                 tlast;
    logic [1:0]                 tuser;
    wire  [1:0]                 hdr_ready;
    wire  [1:0]                 tready;
    logic                       out_hdr_ready;
    logic                       out_tready;
    wire                        out_hdr_valid;
    wire  [ETH_MAC_W-1:0]       out_dest_mac;
    wire  [ETH_MAC_W-1:0]       out_src_mac;
    wire  [ETH_TYPE_W-1:0]      out_eth_type;
    wire  [ETH_DATA_W-1:0]      out_tdata;
    wire  [ETH_KEEP_W-1:0]      out_tkeep;
    wire                        out_tvalid;
    wire                        out_tlast;
    wire                        out_tuser;
    int                         chk_errors;
    int                         chk_pending;
    int                         timeouts;
    logic                       bp_on;
    integer                     seed = 32'haf6e_c4d0;
    integer                     bp_seed = 32'haf6e_c4d0;

    eth_rx_path_top #(
        .PASS_TYPE_0 (PASS_TYPE_0),
        .PASS_TYPE_1 (PASS_TYPE_1)
    ) dut0 (
        .in0_hdr_valid (hdr_valid[0]),
        .in0_hdr_ready (hdr_ready[0]),
        .in0_dest_mac  (dest_mac[0]),
        .in0_src_mac   (src_mac[0]),
        .in0_eth_type  (eth_type[0]),
        .in0_tdata     (tdata[0]),
        .in0_tkeep     (tkeep[0]),
        .in0_tvalid    (tvalid[0]),
        .in0_tready    (tready[0]),
        .in0_tlast     (tlast[0]),
        .in0_tuser     (tuser[0]),
        .in1_hdr_valid (hdr_valid[1]),
        .in1_hdr_ready (hdr_ready[1]),
        .in1_dest_mac  (dest_mac[1]),
        .in1_src_mac   (src_mac[1]),
        .in1_eth_type  (eth_type[1]),
        .in1_tdata     (tdata[1]),
        .in1_tkeep     (tkeep[1]),
        .in1_tvalid    (tvalid[1]),
        .in1_tready    (tready[1]),
        .in1_tlast     (tlast[1]),
        .in1_tuser     (tuser[1]),
        .*
    );

    eth_rx_checker #(
        .PASS_TYPE_0 (PASS_TYPE_0),
        .PASS_TYPE_1 (PASS_TYPE_1)
    ) chk0 (
        .in_hdr_valid  (hdr_valid),
        .in_hdr_ready  (hdr_ready),
        .in_dest_mac   (dest_mac),
        .in_src_mac    (src_mac),
        .in_eth_type   (eth_type),
        .in_tdata      (tdata),
        .in_tkeep      (tkeep),
        .in_tvalid     (tvalid),
        .in_tready     (tready),
        .in_tlast      (tlast),
        .in_tuser      (tuser),
        .error_count   (chk_errors),
        .pending_count (chk_pending),
        .*
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // output side back-pressure that runs at full rate unless bp_on
    initial begin
        logic [31:0] r;
        out_hdr_ready = 1'b0;
        out_tready    = 1'b0;
        forever begin
            @(negedge clk);
            r = $random(bp_seed);
            out_tready    = bp_on ? r[0] : 1'b1;
            out_hdr_ready = bp_on ? r[1] : 1'b1;
        end
    end

    function automatic int draw_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r[15:0]) % n;
    endfunction

    // kind 0 and 1 give the pass types and anything else gives a dropped type
    function automatic logic [ETH_TYPE_W-1:0] draw_type(input int kind);
        logic [31:0] r;
        r = $random(seed);
        if (kind == 0) begin
            return PASS_TYPE_0;
        end
        if (kind == 1) begin
            return PASS_TYPE_1;
        end
        if (r[ETH_TYPE_W-1:0] == PASS_TYPE_0 || r[ETH_TYPE_W-1:0] == PASS_TYPE_1) begin
            return 16'h88B5;
        end
        return r[ETH_TYPE_W-1:0];
    endfunction

    task automatic send_frame(input int port, input logic [ETH_TYPE_W-1:0] etype,
                              input int nbeats, input bit wander);
        logic [31:0] r0;
        logic [31:0] r1;
        int          cnt;
        @(negedge clk);
        r0 = $random(seed);
        r1 = $random(seed);
        select          = port[0];
        dest_mac[port]  = {r0[15:0], r1};
        src_mac[port]   = {r1[15:0], r0};
        eth_type[port]  = etype;
        hdr_valid[port] = 1'b1;
        cnt = 0;
        while (!hdr_ready[port] && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (cnt >= WAIT_LIMIT) begin
            $display("timeout: header on input %0d was never accepted", port);
            timeouts++;
        end
        for (int i = 0; i < nbeats; i++) begin
            @(negedge clk);
            r0 = $random(seed);
            r1 = $random(seed);
            hdr_valid[port] = 1'b0;
            // select may move once the header is in and the frame must stay whole
            if (wander) begin
                select = r0[31];
            end
            tdata[port]  = {r0, r1};
            tkeep[port]  = (i == nbeats - 1) ? (r1[ETH_KEEP_W-1:0] | 8'h01) : {ETH_KEEP_W{1'b1}};
            tlast[port]  = (i == nbeats - 1);
            tuser[port]  = r0[30];
            tvalid[port] = 1'b1;
            cnt = 0;
            while (!tready[port] && cnt < WAIT_LIMIT) begin
                @(negedge clk);
                cnt++;
            end
            if (cnt >= WAIT_LIMIT) begin
                $display("timeout: beat %0d on input %0d was never accepted", i, port);
                timeouts++;
            end
        end
        @(negedge clk);
        hdr_valid[port] = 1'b0;
        tvalid[port]    = 1'b0;
        tlast[port]     = 1'b0;
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (chk_pending != 0 && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (chk_pending != 0) begin
            $display("timeout: output never drained, %0d items still expected", chk_pending);
            timeouts++;
        end
    endtask

    initial begin
        rst       = 1'b1;
        enable    = 1'b0;
        select    = 1'b0;
        hdr_valid = '0;
        dest_mac  = '0;
        src_mac   = '0;
        eth_type  = '0;
        tdata     = '0;
        tkeep     = '0;
        tvalid    = '0;
        tlast     = '0;
        tuser     = '0;
        bp_on     = 1'b0;
        timeouts  = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst    = 1'b0;
        enable = 1'b1;

        // input 0 only with matching types
        for (int i = 0; i < 4; i++) begin
            send_frame(0, draw_type(i % 2), draw_below(6) + 1, 1'b0);
        end
        // inputs take turns while select wanders inside each frame
        for (int i = 0; i < 6; i++) begin
            send_frame(i % 2, draw_type(i % 2), draw_below(6) + 1, 1'b1);
        end
        // dropped types mixed in
        for (int i = 0; i < 9; i++) begin
            send_frame(draw_below(2), draw_type(i % 3), draw_below(6) + 1, 1'b0);
        end
        bp_on = 1'b1;
        for (int i = 0; i < 16; i++) begin
            send_frame(draw_below(2), draw_type(draw_below(3)), draw_below(6) + 1,
                       draw_below(2) == 1);
        end
        wait_drain();
        bp_on = 1'b0;

        // header offered while enable is low and taken once it returns
        @(negedge clk);
        enable = 1'b0;
        fork
            send_frame(1, PASS_TYPE_1, 3, 1'b0);
            begin
                repeat (20) @(negedge clk);
                enable = 1'b1;
            end
        join
        wait_drain();

        $display("checker errors: %0d, timeouts: %0d, expected items left: %0d",
                 chk_errors, timeouts, chk_pending);
        if (chk_errors == 0 && timeouts == 0 && chk_pending == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
